// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and basic types
    //////////////////////////////////////////////////////////////////////

    localparam int FIP_W = 28;                 // 16-byte line address
    localparam int LINE_W = 128;
    localparam int AXI_AW = 32;
    localparam int AXI_DW = 32;

    typedef logic [FIP_W-1:0] fip_t;
    typedef logic [LINE_W-1:0] cache_line_t;
    typedef logic [1:0] line_sel_t;           // byte addr bits 5:4

    typedef struct packed {
        fip_t even;
        fip_t odd;
    } fip_pair_t;

    // control flow source, in rising priority
    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,
        CF_BP      = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_src_t;

    typedef enum logic [1:0] {
        FILL_IDLE  = 2'd0,
        FILL_ADDR  = 2'd1,
        FILL_DATA  = 2'd2,
        FILL_WRITE = 2'd3
    } fill_state_t;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        fip_t        fip;
        cache_line_t line;
    } fill_wr_t;

    typedef struct packed {
        logic              arvalid;
        logic [AXI_AW-1:0] araddr;
        logic              rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic              arready;
        logic [AXI_DW-1:0] rdata;
        logic              rvalid;
    } axil_rd_rsp_t;

    // towards decode
    typedef struct packed {
        cache_line_t even_line;
        cache_line_t odd_line;
        logic        even_hit;
        logic        odd_hit;
        line_sel_t   even_sel;
        line_sel_t   odd_sel;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: rtl/fip_select.sv
`timescale 1ns/1ps
`default_nettype none

module fip_select import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire logic [31:0] init_addr_i,
    input  wire logic        is_init_i,
    input  wire logic        is_resteer_i,
    input  wire logic        is_br_taken_i,
    input  wire fip_pair_t   wb_fip_i,
    input  wire fip_pair_t   bp_fip_i,
    input  wire logic        even_loaded_i,
    input  wire logic        odd_loaded_i,
    output fip_pair_t        fip_o
);

    cf_src_t   cf_src;
    fip_t      init_line;
    fip_t      init_line_p1;
    fip_pair_t init_pair;
    fip_pair_t fip_q;

    ///////////////////////////////////////////////////////////////////////
    // control flow priority
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        if (is_init_i) begin
            cf_src = CF_INIT;
        end else if (is_resteer_i) begin
            cf_src = CF_RESTEER;
        end else if (is_br_taken_i) begin
            cf_src = CF_BP;
        end else begin
            cf_src = CF_NONE;
        end
    end

    // init split on bit 4 of the byte address
    assign init_line    = init_addr_i[31:4];
    assign init_line_p1 = init_line + fip_t'(1);

    always_comb begin
        if (init_addr_i[4]) begin
            init_pair.even = init_line_p1;  // next even line
            init_pair.odd  = init_line;
        end else begin
            init_pair.even = init_line;
            init_pair.odd  = init_line_p1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // even / odd FIP registers
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fip_q.even <= fip_t'(0);
            fip_q.odd  <= fip_t'(1);
        end else begin
            case (cf_src)
                CF_INIT:    fip_q <= init_pair;
                CF_RESTEER: fip_q <= wb_fip_i;
                CF_BP:      fip_q <= bp_fip_i;
                default: begin
                    // each bank moves on its own latch load
                    if (even_loaded_i) begin
                        fip_q.even <= fip_q.even + fip_t'(2);
                    end
                    if (odd_loaded_i) begin
                        fip_q.odd <= fip_q.odd + fip_t'(2);
                    end
                end
            endcase
        end
    end

    assign fip_o = fip_q;

endmodule

`default_nettype wire

// File: rtl/icache_bank.sv
`timescale 1ns/1ps
`default_nettype none

module icache_bank import fetch_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire fip_t        fip_i,
    input  wire logic        we_i,
    input  wire fill_wr_t    fill_i,
    output cache_line_t      line_o,
    output logic             hit_o
);

    localparam int SETS  = 1 << INDEX_BITS;
    localparam int TAG_W = FIP_W - INDEX_BITS - 1;

    // bit 0 of the FIP picks the bank, so it is skipped here
    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] wr_idx;
    logic [TAG_W-1:0]      rd_tag;
    logic [TAG_W-1:0]      wr_tag;

    logic [TAG_W-1:0] tag_mem  [SETS];
    cache_line_t      data_mem [SETS];
    logic [SETS-1:0]  valid_q;

    assign rd_idx = fip_i[INDEX_BITS:1];
    assign rd_tag = fip_i[FIP_W-1:INDEX_BITS+1];
    assign wr_idx = fill_i.fip[INDEX_BITS:1];
    assign wr_tag = fill_i.fip[FIP_W-1:INDEX_BITS+1];

    ///////////////////////////////////////////////////////////////////////
    // lookup
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        hit_o  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        line_o = data_mem[rd_idx];          // only meaningful on a hit
    end

    ///////////////////////////////////////////////////////////////////////
    // fill write
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_idx]  <= wr_tag;
            data_mem[wr_idx] <= fill_i.line;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fill_ctrl import fetch_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_i,
    input  wire fip_pair_t    fip_i,
    input  wire logic         even_miss_i,
    input  wire logic         odd_miss_i,
    output axil_rd_req_t      axi_req_o,
    input  wire axil_rd_rsp_t axi_rsp_i,
    input  wire logic [1:0]   beat_idx_i,
    input  wire logic         last_beat_i,
    input  wire cache_line_t  line_i,
    output logic              start_o,
    output logic              beat_o,
    output fill_wr_t          fill_o,
    output logic              we_even_o,
    output logic              we_odd_o
);

    fill_state_t state_q;
    fill_state_t state_d;
    fip_t        fill_fip_q;    // line being filled
    logic        serve_odd_q;   // bank being filled
    logic        any_miss;

    assign any_miss = even_miss_i || odd_miss_i;

    ///////////////////////////////////////////////////////////////////////
    // next state
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL_IDLE: begin
                if (any_miss) begin
                    state_d = FILL_ADDR;
                end
            end
            FILL_ADDR: begin
                if (axi_rsp_i.arready) begin
                    state_d = FILL_DATA;
                end
            end
            FILL_DATA: begin
                if (axi_rsp_i.rvalid) begin
                    state_d = last_beat_i ? FILL_WRITE : FILL_ADDR;
                end
            end
            FILL_WRITE: state_d = FILL_IDLE;
            default:    state_d = FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= FILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture the missing bank, even first
    always_ff @(posedge clk) begin
        if (rst_i) begin
            serve_odd_q <= 1'b0;
        end else if (state_q == FILL_IDLE && any_miss) begin
            serve_odd_q <= !even_miss_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FILL_IDLE && any_miss) begin
            fill_fip_q <= even_miss_i ? fip_i.even : fip_i.odd;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // AXI4-Lite read side
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        axi_req_o.arvalid = (state_q == FILL_ADDR);
        axi_req_o.araddr  = {fill_fip_q, beat_idx_i, 2'b00};    // line*16 + 4*beat
        axi_req_o.rready  = (state_q == FILL_DATA);
    end

    assign start_o = (state_q == FILL_IDLE) && any_miss;  // clears the beat counter
    assign beat_o  = (state_q == FILL_DATA) && axi_rsp_i.rvalid;

    ///////////////////////////////////////////////////////////////////////
    // bank write
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        fill_o.fip  = fill_fip_q;
        fill_o.line = line_i;
    end

    assign we_even_o = (state_q == FILL_WRITE) && !serve_odd_q;
    assign we_odd_o  = (state_q == FILL_WRITE) && serve_odd_q;

endmodule

`default_nettype wire

// File: rtl/line_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module line_assembler import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire logic        start_i,
    input  wire logic        beat_i,
    input  wire logic [31:0] rdata_i,
    output logic [1:0]       beat_idx_o,
    output logic             last_beat_o,
    output cache_line_t      line_o
);

    logic [1:0]  beat_q;
    cache_line_t line_q;

    // beat counter
    always_ff @(posedge clk) begin
        if (rst_i || start_i) begin
            beat_q <= 2'd0;
        end else if (beat_i) begin
            beat_q <= beat_q + 2'd1;    // wraps after the last beat
        end
    end

    // beat 0 lands in the low word
    always_ff @(posedge clk) begin
        if (beat_i) begin
            line_q[beat_q*32 +: 32] <= rdata_i;
        end
    end

    assign beat_idx_o  = beat_q;
    assign last_beat_o = (beat_q == 2'd3);
    assign line_o      = line_q;

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  wire logic         clk,
    input  wire logic         rst_i,
    input  wire logic [31:0]  init_addr_i,
    input  wire logic         is_init_i,
    input  wire logic         is_resteer_i,
    input  wire logic         is_br_taken_i,
    input  wire fip_pair_t    wb_fip_i,
    input  wire fip_pair_t    bp_fip_i,
    input  wire logic         even_loaded_i,
    input  wire logic         odd_loaded_i,
    output fetch_out_t        fetch_o,
    output axil_rd_req_t      axi_req_o,
    input  wire axil_rd_rsp_t axi_rsp_i
);

    fip_pair_t   fip;
    cache_line_t even_line;
    cache_line_t odd_line;
    logic        even_hit;
    logic        odd_hit;
    fill_wr_t    fill_wr;
    logic        we_even;
    logic        we_odd;
    logic        start;
    logic        beat;
    logic [1:0]  beat_idx;
    logic        last_beat;
    cache_line_t asm_line;

    ///////////////////////////////////////////////////////////////////////
    // address select and banks
    ///////////////////////////////////////////////////////////////////////

    fip_select u_fip_select (
        .clk           (clk),
        .rst_i         (rst_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_taken_i (is_br_taken_i),
        .wb_fip_i      (wb_fip_i),
        .bp_fip_i      (bp_fip_i),
        .even_loaded_i (even_loaded_i),
        .odd_loaded_i  (odd_loaded_i),
        .fip_o         (fip)
    );

    icache_bank #(.INDEX_BITS(INDEX_BITS)) u_bank_even (
        .clk    (clk),
        .rst_i  (rst_i),
        .fip_i  (fip.even),
        .we_i   (we_even),
        .fill_i (fill_wr),
        .line_o (even_line),
        .hit_o  (even_hit)
    );

    icache_bank #(.INDEX_BITS(INDEX_BITS)) u_bank_odd (
        .clk    (clk),
        .rst_i  (rst_i),
        .fip_i  (fip.odd),
        .we_i   (we_odd),
        .fill_i (fill_wr),
        .line_o (odd_line),
        .hit_o  (odd_hit)
    );

    ///////////////////////////////////////////////////////////////////////
    // miss fill path
    ///////////////////////////////////////////////////////////////////////

    fill_ctrl u_fill_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .fip_i       (fip),
        .even_miss_i (!even_hit),
        .odd_miss_i  (!odd_hit),
        .axi_req_o   (axi_req_o),
        .axi_rsp_i   (axi_rsp_i),
        .beat_idx_i  (beat_idx),
        .last_beat_i (last_beat),
        .line_i      (asm_line),
        .start_o     (start),
        .beat_o      (beat),
        .fill_o      (fill_wr),
        .we_even_o   (we_even),
        .we_odd_o    (we_odd)
    );

    line_assembler u_line_assembler (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start),
        .beat_i      (beat),
        .rdata_i     (axi_rsp_i.rdata),
        .beat_idx_o  (beat_idx),
        .last_beat_o (last_beat),
        .line_o      (asm_line)
    );

    // decode side, sel bits are fip bits 1:0
    always_comb begin
        fetch_o.even_line = even_line;
        fetch_o.odd_line  = odd_line;
        fetch_o.even_hit  = even_hit;
        fetch_o.odd_hit   = odd_hit;
        fetch_o.even_sel  = fip.even[1:0];
        fetch_o.odd_sel   = fip.odd[1:0];
    end

endmodule

`default_nettype wire

// File: testbench/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

    localparam int INDEX_BITS  = 4;
    localparam int SETS        = 1 << INDEX_BITS;
    localparam int HIT_TIMEOUT = 500;          // cycles
    localparam logic [31:0] DATA_MASK = 32'h5A5A_0000;

    logic         clk;
    logic         rst;
    logic [31:0]  init_addr;
    logic         is_init;
    logic         is_resteer;
    logic         is_br_taken;
    fip_pair_t    wb_fip;
    fip_pair_t    bp_fip;
    logic         even_loaded;
    logic         odd_loaded;
    fetch_out_t   fetch_out;
    axil_rd_req_t axi_req;
    axil_rd_rsp_t axi_rsp;

    int          check_errors = 0;
    int          protocol_errors = 0;
    int          other_errors = 0;
    int          ar_count = 0;      // AR handshakes seen by the memory model
    fip_t        ref_even;
    fip_t        ref_odd;
    logic [31:0] lcg_state;

    // which line each set of each bank holds
    fip_t model_fip   [2][SETS];
    logic model_valid [2][SETS];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    fetch_top #(.INDEX_BITS(INDEX_BITS)) DUT (
        .clk           (clk),
        .rst_i         (rst),
        .init_addr_i   (init_addr),
        .is_init_i     (is_init),
        .is_resteer_i  (is_resteer),
        .is_br_taken_i (is_br_taken),
        .wb_fip_i      (wb_fip),
        .bp_fip_i      (bp_fip),
        .even_loaded_i (even_loaded),
        .odd_loaded_i  (odd_loaded),
        .fetch_o       (fetch_out),
        .axi_req_o     (axi_req),
        .axi_rsp_i     (axi_rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // reference helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    // the even bank always takes the even one of the two lines
    function automatic fip_pair_t split_addr(logic [31:0] addr);
        fip_pair_t pair;
        if (addr[4]) begin
            pair.even = addr[31:4] + fip_t'(1);
            pair.odd  = addr[31:4];
        end else begin
            pair.even = addr[31:4];
            pair.odd  = addr[31:4] + fip_t'(1);
        end
        return pair;
    endfunction

    function automatic cache_line_t expected_line(fip_t fip);
        cache_line_t line;
        logic [31:0] byte_addr;
        int          k;
        for (k = 0; k < 4; k++) begin
            byte_addr = {fip, 4'b0000} + 32'(4 * k);
            line[k*32 +: 32] = byte_addr ^ DATA_MASK;   // memory rule
        end
        return line;
    endfunction

    // 1 if the line has to be fetched, and marks it present
    function automatic int note_fill(int bank, fip_t fip);
        int idx;
        idx = int'(fip[INDEX_BITS:1]);
        if (model_valid[bank][idx] && model_fip[bank][idx] == fip) begin
            return 0;
        end
        model_valid[bank][idx] = 1'b1;
        model_fip[bank][idx]   = fip;
        return 1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_line(string name, cache_line_t exp, cache_line_t act);
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(string name, line_sel_t exp, line_sel_t act);
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_quiet();
        check_flag("arvalid", 1'b0, axi_req.arvalid);
        check_flag("rready", 1'b0, axi_req.rready);
        check_flag("even_hit", 1'b0, fetch_out.even_hit);
        check_flag("odd_hit", 1'b0, fetch_out.odd_hit);
    endtask

    task automatic check_fetch(int reads_before, int exp_reads, line_sel_t exp_even_sel,
                               line_sel_t exp_odd_sel);
        check_line("even_line", expected_line(ref_even), fetch_out.even_line);
        check_line("odd_line", expected_line(ref_odd), fetch_out.odd_line);
        check_sel("even_sel", exp_even_sel, fetch_out.even_sel);
        check_sel("odd_sel", exp_odd_sel, fetch_out.odd_sel);
        check_count("ar_handshakes", exp_reads, ar_count - reads_before);
    endtask

    task automatic finish_run();
        $display("errors: check %0d, protocol %0d, other %0d",
                 check_errors, protocol_errors, other_errors);
        if (check_errors + protocol_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic wait_hits(output bit hits_ok);
        int cycles;
        cycles  = 0;
        hits_ok = 1'b1;
        @(negedge clk);
        while (!(fetch_out.even_hit && fetch_out.odd_hit) && cycles < HIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(fetch_out.even_hit && fetch_out.odd_hit)) begin
            other_errors++;
            $display("ERROR: fetch hit never arrived, t=%0t", $time);
            hits_ok = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one step of the stimulus file
    //////////////////////////////////////////////////////////////////////

    task automatic run_step(string cmd, logic [31:0] addr, line_sel_t exp_even_sel,
                            line_sel_t exp_odd_sel, output bit step_ok);
        fip_pair_t target;
        int        reads_before;
        int        exp_reads;
        reads_before = ar_count;
        target.even  = ref_even;
        target.odd   = ref_odd;
        @(posedge clk);
        #5;
        if (cmd == "init") begin
            init_addr = addr;
            is_init   = 1'b1;
            target    = split_addr(addr);
        end else if (cmd == "resteer") begin
            wb_fip     = split_addr(addr);
            is_resteer = 1'b1;
            target     = split_addr(addr);
        end else if (cmd == "branch") begin
            bp_fip      = split_addr(addr);
            is_br_taken = 1'b1;
            target      = split_addr(addr);
        end else if (cmd == "init_rs_br") begin
            init_addr   = addr;
            wb_fip      = split_addr(addr + 32'h100);   // loses to init
            bp_fip      = split_addr(addr + 32'h200);
            is_init     = 1'b1;
            is_resteer  = 1'b1;
            is_br_taken = 1'b1;
            target      = split_addr(addr);
        end else if (cmd == "rs_br") begin
            wb_fip      = split_addr(addr);
            bp_fip      = split_addr(addr + 32'h200);   // loses to resteer
            is_resteer  = 1'b1;
            is_br_taken = 1'b1;
            target      = split_addr(addr);
        end else if (cmd == "adv_even") begin
            even_loaded = 1'b1;
            target.even = ref_even + fip_t'(2);
        end else if (cmd == "adv_odd") begin
            odd_loaded = 1'b1;
            target.odd = ref_odd + fip_t'(2);
        end else begin
            other_errors++;
            $display("ERROR: unknown command %s in stimulus file", cmd);
        end
        @(posedge clk);      // FIP pair loads on this edge
        #5;
        is_init     = 1'b0;
        is_resteer  = 1'b0;
        is_br_taken = 1'b0;
        even_loaded = 1'b0;
        odd_loaded  = 1'b0;
        ref_even    = target.even;
        ref_odd     = target.odd;
        exp_reads   = 4 * (note_fill(0, ref_even) + note_fill(1, ref_odd));
        wait_hits(step_ok);
        if (step_ok) begin
            check_fetch(reads_before, exp_reads, exp_even_sel, exp_odd_sel);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite read slave
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic        s_arvalid;
        logic [31:0] s_araddr;
        logic        ar_hs;
        logic        r_hs;
        logic        ar_waiting;
        logic [31:0] wait_addr;
        logic [31:0] pend_addr;
        logic        r_pend;
        int          ar_delay;
        int          r_delay;
        lcg_state  = 32'd62228;
        axi_rsp    = '0;
        ar_waiting = 1'b0;
        wait_addr  = '0;
        pend_addr  = '0;
        r_pend     = 1'b0;
        ar_delay   = next_rand() % 4;
        r_delay    = 0;
        forever begin
            @(negedge clk);           // values here hold until the next edge
            s_arvalid = axi_req.arvalid;
            s_araddr  = axi_req.araddr;
            ar_hs     = s_arvalid && axi_rsp.arready;
            r_hs      = axi_req.rready && axi_rsp.rvalid;
            if (ar_waiting && !s_arvalid) begin
                protocol_errors++;
                $display("ERROR: arvalid dropped before its handshake, t=%0t", $time);
            end else if (ar_waiting && s_araddr !== wait_addr) begin
                protocol_errors++;
                $display("ERROR: araddr changed while arvalid waited, t=%0t", $time);
            end
            ar_waiting = s_arvalid && !ar_hs;
            wait_addr  = s_araddr;
            @(posedge clk);
            #5;
            if (ar_hs) begin
                axi_rsp.arready = 1'b0;
                pend_addr = s_araddr;
                r_pend    = 1'b1;
                r_delay   = next_rand() % 4;
                ar_delay  = next_rand() % 4;    // for the next request
                ar_count++;
            end else if (s_arvalid) begin
                if (ar_delay == 0) begin
                    axi_rsp.arready = 1'b1;
                end else begin
                    ar_delay--;
                end
            end
            if (r_hs) begin
                axi_rsp.rvalid = 1'b0;
            end else if (r_pend) begin
                if (r_delay == 0) begin
                    axi_rsp.rvalid = 1'b1;
                    axi_rsp.rdata  = pend_addr ^ DATA_MASK;
                    r_pend = 1'b0;
                end else begin
                    r_delay--;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          fields;
        int          steps;
        int          exp_reads;
        int          b;
        int          s;
        bit          hits_ok;
        string       text;
        string       cmd;
        logic [31:0] addr;
        line_sel_t   exp_even_sel;
        line_sel_t   exp_odd_sel;
        rst         = 1'b1;
        init_addr   = '0;
        is_init     = 1'b0;
        is_resteer  = 1'b0;
        is_br_taken = 1'b0;
        wb_fip      = '0;
        bp_fip      = '0;
        even_loaded = 1'b0;
        odd_loaded  = 1'b0;
        steps       = 0;
        for (b = 0; b < 2; b++) begin
            for (s = 0; s < SETS; s++) begin
                model_valid[b][s] = 1'b0;
                model_fip[b][s]   = '0;
            end
        end
        repeat (15) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);               // 16th edge in reset
        #5;
        rst = 1'b0;
        @(negedge clk);
        check_quiet();                // first cycle out of reset
        // reset pair 0 and 1 gets filled first
        ref_even  = fip_t'(0);
        ref_odd   = fip_t'(1);
        exp_reads = 4 * (note_fill(0, ref_even) + note_fill(1, ref_odd));
        wait_hits(hits_ok);
        if (hits_ok) begin
            check_fetch(0, exp_reads, 2'd0, 2'd1);
        end
        fd = $fopen("testbench/fetch_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: stimulus file testbench/fetch_input.txt could not be opened");
        end else begin
            while (hits_ok && $fgets(text, fd) != 0) begin
                fields = $sscanf(text, "%s %h %h %h", cmd, addr, exp_even_sel, exp_odd_sel);
                if (text.substr(0, 0) == "#" || fields <= 0) begin
                    // comment or blank
                end else if (fields != 4) begin
                    other_errors++;
                    $display("ERROR: malformed stimulus line: %s", text);
                end else begin
                    run_step(cmd, addr, exp_even_sel, exp_odd_sel, hits_ok);
                    steps++;
                end
            end
            $fclose(fd);
            if (hits_ok && steps == 0) begin
                other_errors++;
                $display("ERROR: no steps read from the stimulus file");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: testbench/fetch_input.txt
# command     byte address (hex)   expected even line_sel   expected odd line_sel
# adv_even / adv_odd ignore the address; init_rs_br and rs_br test the priority
init        00000040  0  1
init        00000050  2  1
init        00000070  0  3
adv_even    00000000  2  3
adv_odd     00000000  2  1
resteer     00000120  2  3
branch      000000b0  0  3
init_rs_br  00000200  0  1
rs_br       00000160  2  3
# revisits, no new reads
resteer     00000040  0  1
branch      00000050  2  1
# lines 0 and 1 were replaced by 32 and 33
init        00000000  0  1
init        00000200  0  1
adv_even    00000000  2  1
adv_odd     00000000  2  3
resteer     000000a0  2  3
init        00000130  0  3
branch      00001010  2  1
adv_odd     00000000  2  3
# priority again, on lines that hit
init_rs_br  00000040  0  1
rs_br       000000b0  0  3

// File: project.f
rtl/fetch_pkg.sv
rtl/fip_select.sv
rtl/icache_bank.sv
rtl/fill_ctrl.sv
rtl/line_assembler.sv
rtl/fetch_top.sv
testbench/tb_fetch.sv
